// File: common/centipede_pkg.sv
// Centipede I/O shared definitions
`default_nettype none

package centipede_pkg;

   // host bus widths
   localparam int ADDR_W = 14;
   localparam int DATA_W = 8;

   // 1 KB regions, selected by address bits 13..10
   localparam logic [3:0] REG_SWITCH    = 4'd2;
   localparam logic [3:0] REG_INPUT     = 4'd3;
   localparam logic [3:0] REG_COLOR_EA  = 4'd5;
   localparam logic [3:0] REG_OUT_LATCH = 4'd7;
   localparam logic [3:0] REG_STEERCLR  = 4'd9;

   // EA sub-selects on address bits 8..7 (with bit 9 set)
   localparam logic [1:0] EA_ADDR = 2'd0;
   localparam logic [1:0] EA_CTRL = 2'd1;
   localparam logic [1:0] EA_READ = 2'd2;

   // memory depths
   localparam int HS_DEPTH   = 64;
   localparam int CRAM_DEPTH = 16;

   // host request, APB style
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [ADDR_W-1:0] paddr;
      logic [DATA_W-1:0] pwdata;
   } apb_req_t;

   // qualified write strobes plus the address and data they go with
   typedef struct packed {
      logic              out_latch;
      logic              steerclr;
      logic              color;
      logic              ea_addr;
      // per-bit enables of the EA control register
      logic [3:0]        ea_ctrl;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } bus_wr_t;

   // player switches, same bit order as the board connector
   typedef struct packed {
      logic coin_r;
      logic coin_c;
      logic coin_l;
      logic self_test;
      logic cocktail;
      logic slam;
      logic start1;
      logic start2;
      logic fire2;
      logic fire1;
   } player_in_t;

   // raw trackball lines, player 1 then player 2
   typedef struct packed {
      logic p1_h_dir;
      logic p1_h_ck;
      logic p1_v_dir;
      logic p1_v_ck;
      logic p2_h_dir;
      logic p2_h_ck;
      logic p2_v_dir;
      logic p2_v_ck;
   } trak_in_t;

   // trackball counter state as seen by the input ports
   typedef struct packed {
      logic       dir1;
      logic [3:0] h_cnt;
      logic       dir2;
      logic [3:0] v_cnt;
   } trak_cnt_t;

   // control latch layout, bit 7 down to bit 0
   typedef struct packed {
      logic       flip;
      logic [3:0] led;
      // right, centre, left
      logic [2:0] coin_drive;
   } ctrl_out_t;

endpackage

`default_nettype wire

// File: rtl/inputs/input_ports.sv
// Player, joystick and switch read ports
`default_nettype none

module input_ports import centipede_pkg::*;
(
   input  wire  [ADDR_W-1:0] rd_addr_i,
   input  player_in_t        player_i,
   input  wire  [7:0]        joystick_i,
   input  wire  [7:0]        sw1_i,
   input  wire  [7:0]        sw2_i,
   input  wire               vblank_i,
   input  ctrl_out_t         ctrl_i,
   input  trak_cnt_t         trak_i,
   output logic [DATA_W-1:0] in_rdata_o
);

   logic [3:0] region;
   logic       coin_r;
   logic       coin_c;
   logic       coin_l;

   assign region = rd_addr_i[ADDR_W-1:ADDR_W-4];

   // a driven coin counter reads back as an inserted coin
   assign coin_r = player_i.coin_r | ctrl_i.coin_drive[2];
   assign coin_c = player_i.coin_c | ctrl_i.coin_drive[1];
   assign coin_l = player_i.coin_l | ctrl_i.coin_drive[0];

   always_comb
   begin
      in_rdata_o = '0;
      if (region == REG_INPUT)
      begin
         case (rd_addr_i[1:0])
            // trackball horizontal, vblank and cabinet bits
            2'b00:
            begin
               in_rdata_o = {trak_i.dir1, vblank_i, player_i.self_test,
                             player_i.cocktail, trak_i.h_cnt};
            end
            // coins and buttons
            2'b01:
            begin
               in_rdata_o = {coin_r, coin_c, coin_l, player_i.slam,
                             player_i.fire2, player_i.fire1,
                             player_i.start1, player_i.start2};
            end
            // trackball vertical
            2'b10:
            begin
               in_rdata_o = {trak_i.dir2, 3'b000, trak_i.v_cnt};
            end
            // both joysticks, player 1 in the upper nibble
            default:
            begin
               in_rdata_o = joystick_i;
            end
         endcase
      end
      else if (region == REG_SWITCH)
      begin
         // option banks, bit 0 picks the second one
         in_rdata_o = rd_addr_i[0] ? sw2_i : sw1_i;
      end
   end

endmodule

`default_nettype wire

// File: rtl/inputs/trakball_ctr.sv
// Two-axis trackball counters
`default_nettype none

module trakball_ctr import centipede_pkg::*;
(
   input  wire       s_6mhz,
   input  wire       reset,
   input  trak_in_t  trak_i,
   input  wire       flip_i,
   input  bus_wr_t   wr_i,
   output trak_cnt_t cnt_o
);

   // selected lines, per axis {dir, ck}; axis 1 horizontal, axis 0 vertical
   logic [3:0] sel;
   logic [3:0] sync1_q;
   logic [3:0] sync2_q;
   logic [1:0] ck_prev_q;
   logic [1:0] dir_q;
   logic [3:0] cnt_q [2];

   // flip hands the counters to player 1
   assign sel = flip_i ?
                {trak_i.p1_h_dir, trak_i.p1_h_ck, trak_i.p1_v_dir, trak_i.p1_v_ck} :
                {trak_i.p2_h_dir, trak_i.p2_h_ck, trak_i.p2_v_dir, trak_i.p2_v_ck};

   // two-flop synchronizer on all four lines
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         sync1_q <= '0;
         sync2_q <= '0;
      end
      else
      begin
         sync1_q <= sel;
         sync2_q <= sync1_q;
      end
   end

   for (genvar a = 0; a < 2; a++)
   begin : g_axis
      logic rise;

      // rising edge of the synchronized axis clock
      assign rise = sync2_q[2*a] & ~ck_prev_q[a];

      always_ff @(posedge s_6mhz or posedge reset)
      begin
         if (reset)
         begin
            ck_prev_q[a] <= 1'b0;
            dir_q[a]     <= 1'b0;
            cnt_q[a]     <= '0;
         end
         else
         begin
            ck_prev_q[a] <= sync2_q[2*a];
            if (rise)
            begin
               dir_q[a] <= sync2_q[2*a+1];
            end
            // steerclr wins over a coincident edge
            if (wr_i.steerclr)
            begin
               cnt_q[a] <= '0;
            end
            else if (rise)
            begin
               // wraps modulo 16 in both directions
               cnt_q[a] <= sync2_q[2*a+1] ? cnt_q[a] + 4'd1 : cnt_q[a] - 4'd1;
            end
         end
      end
   end

   assign cnt_o.dir1  = dir_q[1];
   assign cnt_o.h_cnt = cnt_q[1];
   assign cnt_o.dir2  = dir_q[0];
   assign cnt_o.v_cnt = cnt_q[0];

endmodule

`default_nettype wire

// File: rtl/memory/color_ram.sv
// Colour lookup RAM
`default_nettype none

module color_ram import centipede_pkg::*;
(
   input  wire               s_6mhz,
   input  bus_wr_t           wr_i,
   input  wire  [ADDR_W-1:0] rd_addr_i,
   output logic [3:0]        cram_rdata_o
);

   // 16 x 4 bit entries, one per colour code
   logic [3:0] mem [CRAM_DEPTH];

   // host write, low nibble of the data bus
   always_ff @(posedge s_6mhz)
   begin
      if (wr_i.color)
      begin
         mem[wr_i.addr[3:0]] <= wr_i.data[3:0];
      end
   end

   // asynchronous read for the host
   assign cram_rdata_o = mem[rd_addr_i[3:0]];

endmodule

`default_nettype wire

// File: rtl/memory/hiscore_ram.sv
// High-score memory with EA latches
`default_nettype none

module hiscore_ram import centipede_pkg::*;
(
   input  wire               s_6mhz,
   input  wire               reset,
   input  bus_wr_t           wr_i,
   output logic [DATA_W-1:0] hs_rdata_o
);

   // control value that commits a store: bits 0 and 2 set, 1 and 3 clear
   localparam logic [3:0] STORE = 4'b0101;

   logic [5:0]        hs_addr_q;
   logic [DATA_W-1:0] hs_data_q;
   logic [3:0]        hs_ctrl_q;
   logic              ctrl_wr_q;
   logic [DATA_W-1:0] rdata_q;
   logic [DATA_W-1:0] mem [HS_DEPTH];

   // EA address and data latch together, control separately
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         hs_addr_q <= '0;
         hs_data_q <= '0;
         hs_ctrl_q <= '0;
         ctrl_wr_q <= 1'b0;
      end
      else
      begin
         if (wr_i.ea_addr)
         begin
            hs_addr_q <= wr_i.addr[5:0];
            hs_data_q <= wr_i.data;
         end
         for (int i = 0; i < 4; i++)
         begin
            if (wr_i.ea_ctrl[i])
            begin
               hs_ctrl_q[i] <= wr_i.data[i];
            end
         end
         // remembers that the control was just written
         ctrl_wr_q <= |wr_i.ea_ctrl;
      end
   end

   // store in the cycle after a store control value lands
   always_ff @(posedge s_6mhz)
   begin
      if (ctrl_wr_q && hs_ctrl_q == STORE)
      begin
         mem[hs_addr_q] <= hs_data_q;
      end
      // registered read at the latched score address
      rdata_q <= mem[hs_addr_q];
   end

   assign hs_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: rtl/control_latch.sv
// Addressable control latch
`default_nettype none

module control_latch import centipede_pkg::*;
(
   input  wire       s_6mhz,
   input  wire       reset,
   input  bus_wr_t   wr_i,
   output ctrl_out_t ctrl_o
);

   logic [7:0] latch_q;

   // one bit per write, selected by address bits 2..0, value from data bit 7
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         latch_q <= '0;
      end
      else if (wr_i.out_latch)
      begin
         latch_q[wr_i.addr[2:0]] <= wr_i.data[7];
      end
   end

   // bit 7 flip, 6..3 LED 4..1, 2..0 coin drives right, centre, left
   assign ctrl_o = ctrl_out_t'(latch_q);

endmodule

`default_nettype wire

// File: rtl/io_decode.sv
// APB completer and region decoder
`default_nettype none

module io_decode import centipede_pkg::*;
(
   input  wire               s_6mhz,
   input  wire               reset,
   input  apb_req_t          apb_i,
   input  wire  [DATA_W-1:0] in_rdata_i,
   input  wire  [3:0]        cram_rdata_i,
   input  wire  [DATA_W-1:0] hs_rdata_i,
   output bus_wr_t           wr_o,
   output logic [ADDR_W-1:0] rd_addr_o,
   output logic [DATA_W-1:0] prdata_o,
   output logic              pready_o
);

   logic [3:0]        region;
   logic [1:0]        ea_sub;
   logic              access;
   logic              ea_sel;
   logic              ea_rd;
   logic              wait_q;
   logic              ready;
   logic              wr_en;
   logic [DATA_W-1:0] rd_data;

   // 1 KB region from the top four address bits
   assign region = apb_i.paddr[ADDR_W-1:ADDR_W-4];
   assign ea_sub = apb_i.paddr[8:7];

   // access phase of the current transfer
   assign access = apb_i.psel & apb_i.penable;

   // upper half of region 5 is the EA side, lower half the colour RAM
   assign ea_sel = (region == REG_COLOR_EA) & apb_i.paddr[9];
   assign ea_rd  = access & ~apb_i.pwrite & ea_sel & (ea_sub == EA_READ);

   // EA reads wait one cycle for the registered score data
   assign ready = access & (~ea_rd | wait_q);

   // strobes only on the completing edge, so never applied twice
   assign wr_en = ready & apb_i.pwrite;

   // wait flag, high during the second access cycle of an EA read
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         wait_q <= 1'b0;
      end
      else
      begin
         wait_q <= ea_rd & ~wait_q;
      end
   end

   // write strobes to the peripherals
   always_comb
   begin
      wr_o           = '0;
      wr_o.out_latch = wr_en & (region == REG_OUT_LATCH);
      wr_o.steerclr  = wr_en & (region == REG_STEERCLR);
      wr_o.color     = wr_en & (region == REG_COLOR_EA) & ~apb_i.paddr[9];
      wr_o.ea_addr   = wr_en & ea_sel & (ea_sub == EA_ADDR);
      // all four control bits load together
      wr_o.ea_ctrl   = {4{wr_en & ea_sel & (ea_sub == EA_CTRL)}};
      wr_o.addr      = apb_i.paddr;
      wr_o.data      = apb_i.pwdata;
   end

   // read mux, zero for dropped or unmapped regions
   always_comb
   begin
      rd_data = '0;
      case (region)
         REG_SWITCH,
         REG_INPUT:
         begin
            rd_data = in_rdata_i;
         end
         REG_COLOR_EA:
         begin
            if (!apb_i.paddr[9])
            begin
               rd_data = {{(DATA_W-4){1'b0}}, cram_rdata_i};
            end
            else if (ea_sub == EA_READ)
            begin
               rd_data = hs_rdata_i;
            end
         end
         default:
         begin
            rd_data = '0;
         end
      endcase
   end

   assign rd_addr_o = apb_i.paddr;
   assign prdata_o  = rd_data;
   assign pready_o  = ready;

endmodule

`default_nettype wire

// File: rtl/centipede_io.sv
// Centipede I/O block top level
`default_nettype none

module centipede_io import centipede_pkg::*;
(
   input  wire              s_6mhz,
   input  wire              reset,
   input  apb_req_t         apb_i,
   input  player_in_t       player_i,
   input  trak_in_t         trakball_i,
   input  wire  [7:0]       joystick_i,
   input  wire  [7:0]       sw1_i,
   input  wire  [7:0]       sw2_i,
   input  wire              vblank_i,
   output logic [DATA_W-1:0] prdata_o,
   output logic             pready_o,
   output logic [3:0]       led_o
);

   // decoder to peripherals
   bus_wr_t           wr;
   logic [ADDR_W-1:0] rd_addr;

   // peripherals back to decoder
   logic [DATA_W-1:0] in_rdata;
   logic [3:0]        cram_rdata;
   logic [DATA_W-1:0] hs_rdata;

   // latch and trackball state
   ctrl_out_t         ctrl;
   trak_cnt_t         trak_cnt;

   io_decode i_io_decode (
      .s_6mhz       (s_6mhz),
      .reset        (reset),
      .apb_i        (apb_i),
      .in_rdata_i   (in_rdata),
      .cram_rdata_i (cram_rdata),
      .hs_rdata_i   (hs_rdata),
      .wr_o         (wr),
      .rd_addr_o    (rd_addr),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o)
   );

   control_latch i_control_latch (
      .s_6mhz (s_6mhz),
      .reset  (reset),
      .wr_i   (wr),
      .ctrl_o (ctrl)
   );

   input_ports i_input_ports (
      .rd_addr_i  (rd_addr),
      .player_i   (player_i),
      .joystick_i (joystick_i),
      .sw1_i      (sw1_i),
      .sw2_i      (sw2_i),
      .vblank_i   (vblank_i),
      .ctrl_i     (ctrl),
      .trak_i     (trak_cnt),
      .in_rdata_o (in_rdata)
   );

   trakball_ctr i_trakball_ctr (
      .s_6mhz (s_6mhz),
      .reset  (reset),
      .trak_i (trakball_i),
      .flip_i (ctrl.flip),
      .wr_i   (wr),
      .cnt_o  (trak_cnt)
   );

   color_ram i_color_ram (
      .s_6mhz       (s_6mhz),
      .wr_i         (wr),
      .rd_addr_i    (rd_addr),
      .cram_rdata_o (cram_rdata)
   );

   hiscore_ram i_hiscore_ram (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .wr_i       (wr),
      .hs_rdata_o (hs_rdata)
   );

   // LEDs 4..1 straight from the latch
   assign led_o = ctrl.led;

endmodule

`default_nettype wire

// File: bench/tb_centipede_io.sv
// Centipede I/O directed testbench
`default_nettype none

module tb_centipede_io import centipede_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   // tests need under 1500 cycles, so this leaves plenty of margin
   localparam int CYCLE_LIMIT = 4000;

   logic              s_6mhz;
   logic              reset;
   apb_req_t          apb;
   player_in_t        player;
   trak_in_t          trak;
   logic [7:0]        joystick;
   logic [7:0]        sw1;
   logic [7:0]        sw2;
   logic              vblank;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic [3:0]        led;

   int          cycles = 0;
   int          errors;
   int          checks;
   int          tests;
   int          test_errs_start;
   logic [31:0] seed;

   // reference state built from the register rules
   logic [7:0]  latch_exp;
   logic [3:0]  h_exp;
   logic [3:0]  v_exp;
   logic        dir1_exp;
   logic        dir2_exp;
   logic [7:0]  cram_exp [CRAM_DEPTH];
   logic [7:0]  hs_exp [HS_DEPTH];

   centipede_io i_centipede_io (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .apb_i      (apb),
      .player_i   (player),
      .trakball_i (trak),
      .joystick_i (joystick),
      .sw1_i      (sw1),
      .sw2_i      (sw2),
      .vblank_i   (vblank),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .led_o      (led)
   );

   initial
   begin
      s_6mhz = 1'b0;
      forever #20 s_6mhz = ~s_6mhz;
   end

   // run limit
   always @(posedge s_6mhz)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // lcg, numerical recipes constants
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [ADDR_W-1:0] addr_of(input logic [3:0] region,
                                                 input logic [9:0] low);
      return {region, low};
   endfunction

   // expected port layouts, msb first
   function automatic logic [7:0] coin_port();
      return {player.coin_r | latch_exp[2], player.coin_c | latch_exp[1],
              player.coin_l | latch_exp[0], player.slam, player.fire2,
              player.fire1, player.start1, player.start2};
   endfunction

   function automatic logic [7:0] trak_h_port();
      return {dir1_exp, vblank, player.self_test, player.cocktail, h_exp};
   endfunction

   function automatic logic [7:0] trak_v_port();
      return {dir2_exp, 3'b000, v_exp};
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp)
      begin
         $display("Fail at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      tests++;
      if (errors == test_errs_start)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         $display("test %s: %0d mismatches", name, errors - test_errs_start);
      end
      test_errs_start = errors;
   endtask

   // one apb transfer, outputs sampled at the falling edge
   task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                           input logic [7:0] wdata, output logic [7:0] rdata,
                           output int waits);
      @(posedge s_6mhz);
      #2;
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = wr;
      apb.paddr   = addr;
      apb.pwdata  = wdata;
      @(negedge s_6mhz);
      check(pready, 1'b0, "pready high in setup phase");
      @(posedge s_6mhz);
      #2;
      apb.penable = 1'b1;
      waits = 0;
      @(negedge s_6mhz);
      while (!pready)
      begin
         waits++;
         @(posedge s_6mhz);
         #2;
         @(negedge s_6mhz);
      end
      rdata = prdata;
      // completing edge
      @(posedge s_6mhz);
      #2;
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
      logic [7:0] rd;
      int         w;
      apb_xfer(1'b1, addr, data, rd, w);
      check(w, 0, "wait states on write");
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic [7:0] exp,
                           input int exp_waits, input string msg);
      logic [7:0] rd;
      int         w;
      apb_xfer(1'b0, addr, 8'h00, rd, w);
      check(rd, exp, msg);
      check(w, exp_waits, {msg, " wait states"});
   endtask

   task automatic randomize_inputs();
      logic [31:0] r;
      r = next_rand();
      player   = player_in_t'(r[9:0]);
      joystick = r[17:10];
      vblank   = r[18];
      r = next_rand();
      sw1 = r[7:0];
      sw2 = r[15:8];
   endtask

   // other address and data bits random, only a2..a0 and d7 matter
   task automatic set_latch_bit(input logic [2:0] b, input logic v);
      logic [31:0] r;
      r = next_rand();
      apb_write(addr_of(REG_OUT_LATCH, {r[6:0], b}), {v, r[14:8]});
      latch_exp[b] = v;
   endtask

   task automatic test_control_latch();
      logic [31:0] r;
      check(led, 4'h0, "led after reset");
      for (int round = 0; round < 4; round++)
      begin
         r = next_rand();
         for (int b = 0; b < 8; b++)
         begin
            set_latch_bit(3'(b), r[b]);
            check(led, latch_exp[6:3], "led follows latch");
         end
         randomize_inputs();
         apb_read(addr_of(REG_INPUT, 10'd1), coin_port(), 0, "coin override");
      end
      report_test("control latch");
   endtask

   task automatic test_input_ports();
      logic [31:0] r;
      for (int round = 0; round < 6; round++)
      begin
         randomize_inputs();
         r = next_rand();
         apb_read(addr_of(REG_INPUT, 10'd0), trak_h_port(), 0, "port 0 layout");
         apb_read(addr_of(REG_INPUT, 10'd1), coin_port(), 0, "port 1 layout");
         apb_read(addr_of(REG_INPUT, 10'd2), trak_v_port(), 0, "port 2 layout");
         apb_read(addr_of(REG_INPUT, 10'd3), joystick, 0, "joystick port");
         apb_read(addr_of(REG_SWITCH, {r[9:1], 1'b0}), sw1, 0, "switch bank 1");
         apb_read(addr_of(REG_SWITCH, {r[19:11], 1'b1}), sw2, 0, "switch bank 2");
      end
      report_test("input ports");
   endtask

   task automatic test_color_ram();
      logic [31:0] r;
      for (int i = 0; i < CRAM_DEPTH; i++)
      begin
         r = next_rand();
         cram_exp[i] = {4'h0, r[3:0]};
         // bit 9 low selects the colour RAM, bits 8..4 are don't care
         apb_write(addr_of(REG_COLOR_EA, {1'b0, r[12:8], 4'(i)}), r[7:0]);
      end
      for (int i = 0; i < CRAM_DEPTH; i++)
      begin
         apb_read(addr_of(REG_COLOR_EA, {6'd0, 4'(i)}), cram_exp[i], 0, "colour entry");
      end
      report_test("colour ram");
   endtask

   task automatic read_score(input logic [5:0] k, input string msg);
      apb_write(addr_of(REG_COLOR_EA, {1'b1, EA_ADDR, 1'b0, k}), 8'h00);
      apb_read(addr_of(REG_COLOR_EA, {1'b1, EA_READ, 7'd0}), hs_exp[k], 1, msg);
   endtask

   task automatic test_hiscore();
      logic [31:0] r;
      logic [5:0]  k;
      logic [3:0]  no_store [5];
      no_store = '{4'b0001, 4'b0100, 4'b1101, 4'b0111, 4'b0000};
      for (int i = 0; i < 8; i++)
      begin
         r = next_rand();
         k = 6'(i * 7 + 3);
         hs_exp[k] = r[7:0];
         apb_write(addr_of(REG_COLOR_EA, {1'b1, EA_ADDR, 1'b0, k}), r[7:0]);
         apb_write(addr_of(REG_COLOR_EA, {1'b1, EA_CTRL, 7'd0}), {r[11:8], 4'b0101});
      end
      for (int i = 0; i < 8; i++)
      begin
         read_score(6'(i * 7 + 3), "score entry");
      end
      // address and control registers read as zero, without a wait state
      apb_read(addr_of(REG_COLOR_EA, {1'b1, EA_CTRL, 7'd0}), 8'h00, 0, "ea control read");
      apb_read(addr_of(REG_COLOR_EA, {1'b1, EA_ADDR, 7'd0}), 8'h00, 0, "ea address read");
      for (int i = 0; i < 5; i++)
      begin
         r = next_rand();
         k = 6'(i * 7 + 3);
         apb_write(addr_of(REG_COLOR_EA, {1'b1, EA_ADDR, 1'b0, k}), ~hs_exp[k]);
         apb_write(addr_of(REG_COLOR_EA, {1'b1, EA_CTRL, 7'd0}), {r[3:0], no_store[i]});
         read_score(k, "score after non-store control");
      end
      report_test("high score");
   endtask

   // dir set a cycle ahead, then a clean clock pulse
   task automatic pulse_trak(input logic p1, input logic horiz, input logic dir);
      int         base;
      logic [7:0] lines;
      base  = (p1 ? 4 : 0) + (horiz ? 2 : 0);
      lines = trak;
      lines[base+1] = dir;
      trak = trak_in_t'(lines);
      @(posedge s_6mhz);
      #2;
      lines[base] = 1'b1;
      trak = trak_in_t'(lines);
      repeat (3) @(posedge s_6mhz);
      #2;
      lines[base] = 1'b0;
      trak = trak_in_t'(lines);
      repeat (3) @(posedge s_6mhz);
      #2;
      // only the player picked by flip counts
      if (p1 == latch_exp[7])
      begin
         if (horiz)
         begin
            h_exp    = dir ? h_exp + 4'd1 : h_exp - 4'd1;
            dir1_exp = dir;
         end
         else
         begin
            v_exp    = dir ? v_exp + 4'd1 : v_exp - 4'd1;
            dir2_exp = dir;
         end
      end
   endtask

   task automatic check_trak_counts(input string msg);
      repeat (5) @(posedge s_6mhz);
      #2;
      apb_read(addr_of(REG_INPUT, 10'd0), trak_h_port(), 0, {msg, " horizontal"});
      apb_read(addr_of(REG_INPUT, 10'd2), trak_v_port(), 0, {msg, " vertical"});
   endtask

   task automatic test_trakball();
      logic [31:0] r;
      set_latch_bit(3'd7, 1'b0);
      check_trak_counts("counts after reset");
      for (int f = 0; f < 2; f++)
      begin
         if (f == 1)
         begin
            set_latch_bit(3'd7, 1'b1);
         end
         for (int round = 0; round < 3; round++)
         begin
            for (int p = 0; p < 6; p++)
            begin
               r = next_rand();
               // mostly the selected player, some on the other one
               pulse_trak(r[20] ? r[21] : latch_exp[7], r[22], r[23]);
            end
            check_trak_counts("counts");
         end
      end
      r = next_rand();
      apb_write(addr_of(REG_STEERCLR, r[9:0]), r[17:10]);
      h_exp = 4'h0;
      v_exp = 4'h0;
      check_trak_counts("counts after steerclr");
      report_test("trackball");
   endtask

   task automatic test_dropped();
      logic [31:0] r;
      logic [3:0]  dropped [5];
      dropped = '{4'd0, 4'd1, 4'd4, 4'd6, 4'd8};
      for (int i = 0; i < 5; i++)
      begin
         r = next_rand();
         apb_read(addr_of(dropped[i], r[9:0]), 8'h00, 0, "dropped region read");
         apb_write(addr_of(dropped[i], r[19:10]), r[27:20]);
         apb_write(addr_of(dropped[i], {r[9:3], r[30:28]}), 8'hff);
      end
      check(led, latch_exp[6:3], "led after dropped writes");
      for (int i = 0; i < CRAM_DEPTH; i++)
      begin
         apb_read(addr_of(REG_COLOR_EA, {6'd0, 4'(i)}), cram_exp[i], 0, "colour unchanged");
      end
      read_score(6'd3, "score unchanged");
      read_score(6'd52, "score unchanged");
      check_trak_counts("counts unchanged");
      report_test("dropped regions");
   endtask

   initial
   begin
      errors          = 0;
      checks          = 0;
      tests           = 0;
      test_errs_start = 0;
      seed            = 32'h8889dba7;
      latch_exp       = 8'h00;
      h_exp           = 4'h0;
      v_exp           = 4'h0;
      dir1_exp        = 1'b0;
      dir2_exp        = 1'b0;
      reset           = 1'b1;
      apb             = '0;
      player          = '0;
      trak            = '0;
      joystick        = 8'h00;
      sw1             = 8'h00;
      sw2             = 8'h00;
      vblank          = 1'b0;
      repeat (3) @(posedge s_6mhz);
      #2;
      reset = 1'b0;

      test_control_latch();
      test_input_ports();
      test_color_ram();
      test_hiscore();
      test_trakball();
      test_dropped();

      $display("tests %0d, checks %0d, errors %0d, cycles %0d", tests, checks, errors, cycles);
      if (errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
common/centipede_pkg.sv
rtl/inputs/input_ports.sv
rtl/inputs/trakball_ctr.sv
rtl/memory/color_ram.sv
rtl/memory/hiscore_ram.sv
rtl/control_latch.sv
rtl/io_decode.sv
rtl/centipede_io.sv
bench/tb_centipede_io.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_centipede_io
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
